// ==== logic/fetchPkg.sv ====
// ======================================================================
// shared types and constants for the fetch-to-decode stage
// bundle, slot, code-buffer, interrupt and decoded types
// unit codes, opcode, function and fault constants, NOP/interrupt words
// ======================================================================

package fetchPkg;

	// execution unit codes
	typedef logic [2:0] unit_t;
	localparam unit_t UnitBranch = 3'd0;
	localparam unit_t UnitInt    = 3'd1;
	localparam unit_t UnitFloat  = 3'd2;
	localparam unit_t UnitMem    = 3'd3;
	localparam unit_t UnitNone   = 3'd4;

	// 40-bit instruction slot, msb first
	typedef struct packed {
		logic [4:0] funct;
		logic [4:0] resvHi;
		logic [7:0] cause;
		logic [1:0] resvLo;
		logic [3:0] level;
		logic [5:0] rs1;
		logic [3:0] opcode;
		logic [5:0] low;
	} insn_t;

	// template in the top byte, slot 0 in the low bits
	typedef struct packed {
		logic [7:0]      templ;
		insn_t [2:0]     slots;
	} bundle_t;

	typedef struct packed {
		logic [1:0] fault;
		bundle_t    bundle;
	} fetch_t;

	typedef struct packed {
		logic [3:0] level;
		logic [3:0] mask;
		logic [7:0] cause;
	} irqReq_t;

	// execute code buffer entry
	typedef struct packed {
		logic       pad;
		logic [6:0] templ;
		insn_t      insn;
	} cbEntry_t;

	typedef struct packed {
		bundle_t          bundle;
		logic [2:0][7:0]  templ;
		insn_t [2:0]      insn;
	} decoded_t;

	localparam logic [3:0] OpBrk = 4'hF;
	localparam logic [3:0] OpRti = 4'hE;
	localparam logic [4:0] FnPfi = 5'h01;
	localparam logic [4:0] FnExec = 5'h02;

	// fault causes for tlb miss, execute protection and bus error
	localparam logic [7:0] FltTlb = 8'h81;
	localparam logic [7:0] FltExf = 8'h82;
	localparam logic [7:0] FltIbe = 8'h83;

	localparam insn_t NopInsn = insn_t'(40'h00_0000_03C0);

	// interrupt word: brk opcode with function 5'h10 plus level and cause
	function automatic insn_t mkIntInsn(input logic [3:0] level, input logic [7:0] cause);
		insn_t w;
		w = NopInsn;
		w.funct = 5'h10;
		w.cause = cause;
		w.level = level;
		return w;
	endfunction

endpackage

// ==== logic/slotDecode.sv ====
// ======================================================================
// per-slot decode: template to unit lookup for one slot
// plus PFI and EXEC recognition on branch-unit slots
// ======================================================================

`timescale 1ns/1ps

module slotDecode #(
	parameter int Slot = 0
) (
	input  logic [6:0]      templ_i,
	input  fetchPkg::insn_t insn_i,
	output fetchPkg::unit_t unit_o,
	output logic            isPfi_o,
	output logic            isExec_o
);
	import fetchPkg::*;

	// templates below 64 pack two unit bits per slot
	// 7D and 7E are single-op bundles in slot 0
	always_comb begin
		if (templ_i[6] == 1'b0) begin
			unit_o = {1'b0, templ_i[2*Slot +: 2]};
		end else if (templ_i == 7'h7D) begin
			unit_o = (Slot == 0) ? UnitInt : UnitNone;
		end else if (templ_i == 7'h7E) begin
			unit_o = (Slot == 0) ? UnitFloat : UnitNone;
		end else begin
			unit_o = UnitNone;
		end
	end

	// only a branch slot can carry pfi or exec
	assign isPfi_o = (unit_o == UnitBranch)
		&& (insn_i.opcode == OpBrk)
		&& (insn_i.funct == FnPfi);

	assign isExec_o = (unit_o == UnitBranch)
		&& (insn_i.opcode == OpRti)
		&& (insn_i.funct == FnExec);

endmodule

// ==== logic/codeBuffer.sv ====
// ======================================================================
// execute code buffer, 64 entries
// one synchronous write port, three combinational read ports
// ======================================================================

`timescale 1ns/1ps

module codeBuffer (
	input  logic                    clk,
	input  logic                    we_i,
	input  logic [5:0]              wrAddr_i,
	input  fetchPkg::cbEntry_t      wrData_i,
	input  logic [2:0][5:0]         rdAddr_i,
	output fetchPkg::cbEntry_t [2:0] rdData_o
);
	import fetchPkg::*;

	// loaded by software, contents undefined until written
	cbEntry_t mem [0:63];

	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[wrAddr_i] <= wrData_i;
		end
	end

	// one read port per bundle slot
	for (genvar g = 0; g < 3; g++) begin : rdPort
		assign rdData_o[g] = mem[rdAddr_i[g]];
	end

endmodule

// ==== logic/decodeBuffer.sv ====
// ======================================================================
// decode buffer: interrupt, fault, PFI and EXEC substitution
// on the fetched bundle, then the registered decode stage
// ======================================================================

`timescale 1ns/1ps

module decodeBuffer #(
	parameter logic [7:0] BranchTemplate = 8'h00
) (
	input  logic                     clk,
	input  logic                     rst,
	input  fetchPkg::fetch_t         fetch_i,
	input  fetchPkg::irqReq_t        irqReq_i,
	input  logic                     intCommit_i,
	input  logic                     phit_i,
	input  logic                     nextBundle_i,
	input  fetchPkg::cbEntry_t [2:0] cbData_i,
	output logic [2:0][5:0]          cbAddr_o,
	output logic                     freeze_o,
	output fetchPkg::decoded_t       decoded_o
);
	import fetchPkg::*;

	localparam decoded_t ResetDecoded = '{
		bundle: '{templ: BranchTemplate, slots: {3{NopInsn}}},
		templ:  {3{BranchTemplate}},
		insn:   {3{NopInsn}}
	};

	unit_t [2:0] slotUnit;
	logic [2:0]  slotPfi;
	logic [2:0]  slotExec;
	logic        bundleFault;
	logic [7:0]  faultCause;
	insn_t       irqInsn;
	insn_t       faultInsn;
	decoded_t    preview;

	// ==================================================================
	// slot classification
	// ==================================================================

	for (genvar g = 0; g < 3; g++) begin : slotDec
		slotDecode #(
			.Slot(g)
		) uSlot (
			.templ_i (fetch_i.bundle.templ[6:0]),
			.insn_i  (fetch_i.bundle.slots[g]),
			.unit_o  (slotUnit[g]),
			.isPfi_o (slotPfi[g]),
			.isExec_o(slotExec[g])
		);

		// exec slots look up the code buffer at their own rs1
		assign cbAddr_o[g] = fetch_i.bundle.slots[g].rs1;
	end

	// ==================================================================
	// interrupt and fault words
	// ==================================================================

	// pc holds while a pending interrupt is not yet committed
	assign freeze_o = (irqReq_i.level > irqReq_i.mask) && !intCommit_i;

	// an all-zero bundle is treated as a bus error
	assign bundleFault = (fetch_i.fault != 2'd0) || (fetch_i.bundle == '0);

	always_comb begin
		case (fetch_i.fault)
			2'd1:    faultCause = FltTlb;
			2'd2:    faultCause = FltExf;
			default: faultCause = FltIbe;
		endcase
	end

	assign irqInsn   = mkIntInsn(irqReq_i.level, irqReq_i.cause);
	assign faultInsn = mkIntInsn(4'h0, faultCause);

	// ==================================================================
	// preview bundle, rules applied in priority order
	// ==================================================================

	always_comb begin
		logic  takeIrq;
		insn_t subInsn;

		takeIrq = 1'b0;
		subInsn = freeze_o ? irqInsn : faultInsn;

		// default pass-through, bit 7 of the template reads as zero
		preview.bundle = fetch_i.bundle;
		for (int i = 0; i < 3; i++) begin
			preview.templ[i] = {1'b0, fetch_i.bundle.templ[6:0]};
			preview.insn[i]  = fetch_i.bundle.slots[i];
		end

		if (freeze_o || bundleFault) begin
			// whole bundle becomes three interrupt words
			preview.bundle.templ = BranchTemplate;
			for (int i = 0; i < 3; i++) begin
				preview.bundle.slots[i] = subInsn;
				preview.templ[i]        = BranchTemplate;
				preview.insn[i]         = subInsn;
			end
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (takeIrq) begin
					// slots after the interrupting pfi are squashed
					preview.bundle.slots[i] = NopInsn;
					preview.insn[i]         = NopInsn;
				end else if (slotPfi[i] && irqReq_i.level == 4'h0) begin
					preview.bundle.slots[i] = NopInsn;
					preview.insn[i]         = NopInsn;
				end else if (slotPfi[i]) begin
					takeIrq                 = 1'b1;
					preview.bundle.slots[i] = irqInsn;
					preview.insn[i]         = irqInsn;
					// retemplate so the nop slots go to a branch unit
					if (i == 0) begin
						preview.bundle.templ = BranchTemplate;
						for (int j = 0; j < 3; j++) begin
							preview.templ[j] = BranchTemplate;
						end
					end else if (i == 1) begin
						preview.bundle.templ = {5'b0, slotUnit[0]};
						for (int j = 0; j < 3; j++) begin
							preview.templ[j] = {5'b0, slotUnit[0]};
						end
					end
				end else if (slotExec[i]) begin
					// bundle field keeps the exec word itself
					preview.templ[i] = {1'b0, cbData_i[i].templ};
					preview.insn[i]  = cbData_i[i].insn;
				end
			end
		end
	end

	// ==================================================================
	// decode stage register
	// ==================================================================

	// holds while the cache misses or decode stalls
	always_ff @(posedge clk) begin
		if (rst) begin
			decoded_o <= ResetDecoded;
		end else if (phit_i && nextBundle_i) begin
			decoded_o <= preview;
		end
	end

endmodule

// ==== logic/fetchDecodeTop.sv ====
// ======================================================================
// fetch-to-decode top level
// execute code buffer feeding the decode buffer
// ======================================================================

`timescale 1ns/1ps

module fetchDecodeTop #(
	parameter logic [7:0] BranchTemplate = 8'h00
) (
	input  logic                clk,
	input  logic                rst,
	input  fetchPkg::fetch_t    fetch_i,
	input  fetchPkg::irqReq_t   irqReq_i,
	input  logic                intCommit_i,
	input  logic                phit_i,
	input  logic                nextBundle_i,
	input  logic                cbWe_i,
	input  logic [5:0]          cbAddr_i,
	input  fetchPkg::cbEntry_t  cbData_i,
	output fetchPkg::decoded_t  decoded_o,
	output logic                freeze_o
);
	import fetchPkg::*;

	// per-slot lookups from decode into the code buffer
	logic [2:0][5:0] cbRdAddr;
	cbEntry_t [2:0]  cbRdData;

	codeBuffer uCodeBuf (
		.clk     (clk),
		.we_i    (cbWe_i),
		.wrAddr_i(cbAddr_i),
		.wrData_i(cbData_i),
		.rdAddr_i(cbRdAddr),
		.rdData_o(cbRdData)
	);

	decodeBuffer #(
		.BranchTemplate(BranchTemplate)
	) uDecBuf (
		.clk         (clk),
		.rst         (rst),
		.fetch_i     (fetch_i),
		.irqReq_i    (irqReq_i),
		.intCommit_i (intCommit_i),
		.phit_i      (phit_i),
		.nextBundle_i(nextBundle_i),
		.cbData_i    (cbRdData),
		.cbAddr_o    (cbRdAddr),
		.freeze_o    (freeze_o),
		.decoded_o   (decoded_o)
	);

endmodule

// ==== bench/decodeBuffer_assert.sv ====
// ======================================================================
// concurrent checks on the decode buffer, bound into each instance
// ======================================================================

`timescale 1ns/1ps

module decodeBufferAssert (
	input logic               clk,
	input logic               rst,
	input fetchPkg::irqReq_t  irqReq_i,
	input logic               phit_i,
	input logic               nextBundle_i,
	input logic               freeze_o,
	input fetchPkg::decoded_t decoded_o
);
	import fetchPkg::*;

	// back-pressure keeps the decode register
	holdOnStall: assert property (@(posedge clk)
		(!rst && !(phit_i && nextBundle_i)) |=> (rst || $stable(decoded_o)))
		else $error("decoded changed without the hit and next strobes");

	// a frozen fetch loads three interrupt words carrying the request
	freezeRule: assert property (@(posedge clk)
		(!rst && freeze_o && phit_i && nextBundle_i) |=>
		(decoded_o.insn[0].level == $past(irqReq_i.level)
		&& decoded_o.insn[0].cause == $past(irqReq_i.cause)
		&& decoded_o.insn[0].funct == 5'h10
		&& decoded_o.insn[1] == decoded_o.insn[0]
		&& decoded_o.insn[2] == decoded_o.insn[0]))
		else $error("frozen fetch did not load the interrupt words");

	resetValue: assert property (@(posedge clk) rst |=>
		(decoded_o.insn == {3{NopInsn}} && decoded_o.bundle.slots == {3{NopInsn}}
		&& decoded_o.templ == {3{decoded_o.bundle.templ}}))
		else $error("decoded lacks the reset values after reset");

endmodule

bind decodeBuffer decodeBufferAssert uAssert (
	.clk(clk), .rst(rst), .irqReq_i(irqReq_i),
	.phit_i(phit_i), .nextBundle_i(nextBundle_i), .freeze_o(freeze_o),
	.decoded_o(decoded_o)
);

// ==== bench/fetchDecodeTb.sv ====
// ======================================================================
// testbench for the fetch-to-decode stage
// reference model, compare process, directed and random stimulus
// ======================================================================

`timescale 1ns/1ps

module fetchDecodeTb;
	import fetchPkg::*;

	localparam logic [7:0] BranchTmpl = 8'h00;

	logic       clk = 1'b0;
	logic       rst = 1'b1;
	fetch_t     fetch = '0;
	irqReq_t    irqReq = '0;
	logic       intCommit = 1'b0;
	logic       phit = 1'b0;
	logic       nextBundle = 1'b0;
	logic       cbWe = 1'b0;
	logic [5:0] cbAddr = '0;
	cbEntry_t   cbData = '0;
	decoded_t   decodedOut;
	logic       freezeOut;
	cbEntry_t   cbModel [0:63];
	integer     seed = 32'h146;

	fetchDecodeTop #(.BranchTemplate(BranchTmpl)) uut (
		.clk(clk), .rst(rst), .fetch_i(fetch), .irqReq_i(irqReq),
		.intCommit_i(intCommit), .phit_i(phit), .nextBundle_i(nextBundle),
		.cbWe_i(cbWe), .cbAddr_i(cbAddr), .cbData_i(cbData),
		.decoded_o(decodedOut), .freeze_o(freezeOut)
	);

	initial begin
		forever #20 clk = ~clk;
	end

	initial begin
		#200_000;
		stopOnError("simulation ran past its time limit");
	end

	function automatic logic [31:0] rand32();
		rand32 = $random(seed);
	endfunction

	function automatic insn_t randInsn();
		logic [31:0] a;
		logic [31:0] b;
		a = rand32();
		b = rand32();
		randInsn = {a[7:0], b};
	endfunction

	// template index to unit, per slot
	function automatic unit_t unitOf(input logic [6:0] t, input int slot);
		if (t < 7'd64) return {1'b0, t[2*slot +: 2]};
		if (t == 7'h7D) return (slot == 0) ? UnitInt : UnitNone;
		if (t == 7'h7E) return (slot == 0) ? UnitFloat : UnitNone;
		return UnitNone;
	endfunction

	function automatic insn_t intWord(input logic [3:0] level, input logic [7:0] cause);
		intWord = {1'b1, 9'b0, cause, 2'b0, level, 16'h03C0};
	endfunction

	function automatic decoded_t refDecode(input fetch_t f, input irqReq_t irq,
			input logic commit, output logic frz);
		decoded_t   d;
		logic [6:0] t;
		logic [7:0] cause;
		insn_t      sub;
		insn_t      s;
		logic       taken;
		logic       br;
		frz = (irq.level > irq.mask) && !commit;
		t = f.bundle.templ[6:0];
		cause = (f.fault == 2'd1) ? FltTlb : (f.fault == 2'd2) ? FltExf : FltIbe;
		sub = frz ? intWord(irq.level, irq.cause) : intWord(4'h0, cause);
		taken = 1'b0;
		d.bundle = f.bundle;
		for (int i = 0; i < 3; i++) begin
			d.templ[i] = {1'b0, t};
			d.insn[i] = f.bundle.slots[i];
		end
		for (int i = 0; i < 3; i++) begin
			s = f.bundle.slots[i];
			br = (unitOf(t, i) == UnitBranch);
			if (frz || f.fault != 2'd0 || f.bundle == '0) begin
				d.bundle.templ = BranchTmpl;
				d.bundle.slots[i] = sub;
				d.templ[i] = BranchTmpl;
				d.insn[i] = sub;
			end else if (taken || (br && s.opcode == OpBrk && s.funct == FnPfi
					&& irq.level == 4'h0)) begin
				d.bundle.slots[i] = NopInsn;
				d.insn[i] = NopInsn;
			end else if (br && s.opcode == OpBrk && s.funct == FnPfi) begin
				taken = 1'b1;
				d.bundle.slots[i] = intWord(irq.level, irq.cause);
				d.insn[i] = d.bundle.slots[i];
				if (i < 2) begin
					d.bundle.templ = (i == 0) ? BranchTmpl : {5'b0, unitOf(t, 0)};
					d.templ = {3{d.bundle.templ}};
				end
			end else if (br && s.opcode == OpRti && s.funct == FnExec) begin
				d.templ[i] = {1'b0, cbModel[s.rs1].templ};
				d.insn[i] = cbModel[s.rs1].insn;
			end
		end
		return d;
	endfunction

	task automatic stopOnError(input string line);
		$display("%s", line);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkDecoded(input decoded_t got, input decoded_t exp);
		if (got !== exp)
			stopOnError($sformatf("ERROR at %0t: decoded got %h expected %h", $time, got, exp));
	endtask

	task automatic checkFreeze(input logic got, input logic exp);
		if (got !== exp)
			stopOnError($sformatf("ERROR at %0t: freeze got %b expected %b", $time, got, exp));
	endtask

	task automatic driveCycle(input fetch_t f, input irqReq_t irq, input logic commit,
			input logic hit, input logic next);
		@(negedge clk);
		fetch = f;
		irqReq = irq;
		intCommit = commit;
		phit = hit;
		nextBundle = next;
	endtask

	task automatic waitFreeze(input logic level);
		int n;
		n = 0;
		#1;
		while (freezeOut !== level && n < 20) begin
			@(posedge clk);
			n++;
		end
		if (freezeOut !== level)
			stopOnError($sformatf("freeze did not settle to %b in time", level));
	endtask

	// compare process, expected register updated on the same strobe as the DUT
	initial begin
		decoded_t expDec;
		decoded_t nextDec;
		logic     expFrz;
		forever begin
			@(posedge clk);
			nextDec = refDecode(fetch, irqReq, intCommit, expFrz);
			if (rst)
				expDec = '{bundle: '{templ: BranchTmpl, slots: {3{NopInsn}}},
					templ: {3{BranchTmpl}}, insn: {3{NopInsn}}};
			else if (phit && nextBundle)
				expDec = nextDec;
			#1;
			checkDecoded(decodedOut, expDec);
			checkFreeze(freezeOut, expFrz);
		end
	end

	initial begin
		fetch_t      f;
		irqReq_t     irq;
		logic [31:0] r;
		irq = '0;
		repeat (16) @(negedge clk);
		rst = 1'b0;
		// load the code buffer while the strobes stay apart
		for (int a = 0; a < 64; a++) begin
			r = rand32();
			cbModel[a] = '{pad: 1'b0, templ: r[6:0], insn: randInsn()};
			@(negedge clk);
			cbWe = 1'b1;
			cbAddr = a[5:0];
			cbData = cbModel[a];
			phit = r[7];
			nextBundle = !r[7];
		end
		@(negedge clk);
		cbWe = 1'b0;
		// ordinary bundles over every template, random strobes
		f.fault = 2'd0;
		for (int i = 0; i < 256; i++) begin
			r = rand32();
			f.bundle = {1'b0, i[6:0], randInsn(), randInsn(), randInsn()};
			driveCycle(f, irq, 1'b0, r[0] | r[1], r[2] | r[3]);
		end
		// fault codes 1 to 3, then the all-zero bundle
		for (int k = 1; k < 5; k++) begin
			f.fault = (k < 4) ? k[1:0] : 2'd0;
			f.bundle = (k < 4) ? {8'h15, randInsn(), randInsn(), randInsn()} : '0;
			driveCycle(f, irq, 1'b0, 1'b1, 1'b1);
		end
		f = {2'd0, 8'h05, randInsn(), randInsn(), randInsn()};
		irq = '{level: 4'h9, mask: 4'h3, cause: 8'h5A};
		driveCycle(f, irq, 1'b0, 1'b1, 1'b1);
		waitFreeze(1'b1);
		driveCycle(f, irq, 1'b1, 1'b1, 1'b1);
		waitFreeze(1'b0);
		irq.level = 4'h3;
		driveCycle(f, irq, 1'b0, 1'b1, 1'b1);
		waitFreeze(1'b0);
		// pfi on even k and exec on odd k, k of 6 and 7 on a non-branch slot
		repeat (4) for (int s = 0; s < 3; s++) begin
			for (int k = 0; k < 8; k++) begin
				r = rand32();
				f.bundle = {2'b00, r[5:0], randInsn(), randInsn(), randInsn()};
				f.bundle.templ[2*s +: 2] = (k < 6) ? 2'b00 : 2'b01;
				f.bundle.slots[s].opcode = k[0] ? OpRti : OpBrk;
				f.bundle.slots[s].funct = k[0] ? FnExec : FnPfi;
				if (r[24])
					f.bundle.slots[(s + 1) % 3] = f.bundle.slots[s];
				irq = '{level: k[1] ? (r[11:8] | 4'h1) : 4'h0, mask: 4'hF, cause: r[23:16]};
				driveCycle(f, irq, 1'b0, 1'b1, 1'b1);
			end
		end
		driveCycle(f, irq, 1'b0, 1'b0, 1'b0);
		repeat (2) @(negedge clk);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== project.f ====
logic/fetchPkg.sv
logic/slotDecode.sv
logic/codeBuffer.sv
logic/decodeBuffer.sv
logic/fetchDecodeTop.sv
bench/decodeBuffer_assert.sv
bench/fetchDecodeTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch-to-decode testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f project.f --top-module fetchDecodeTb \
	-Mdir obj_dir -o simv
./obj_dir/simv | tee sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
	exit 0
fi
exit 1
